// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int FUNCT3_W = 3;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // only the major opcodes this core executes
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011,
    op_system = 7'b1110011
  } opcode_t;

  // funct3 for register and immediate ALU ops
  localparam logic [FUNCT3_W-1:0] f3_add_sub = 3'b000;
  localparam logic [FUNCT3_W-1:0] f3_sll     = 3'b001;
  localparam logic [FUNCT3_W-1:0] f3_slt     = 3'b010;
  localparam logic [FUNCT3_W-1:0] f3_sltu    = 3'b011;
  localparam logic [FUNCT3_W-1:0] f3_xor     = 3'b100;
  localparam logic [FUNCT3_W-1:0] f3_srl_sra = 3'b101;
  localparam logic [FUNCT3_W-1:0] f3_or      = 3'b110;
  localparam logic [FUNCT3_W-1:0] f3_and     = 3'b111;

  // funct3 for conditional branches
  localparam logic [FUNCT3_W-1:0] f3_beq  = 3'b000;
  localparam logic [FUNCT3_W-1:0] f3_bne  = 3'b001;
  localparam logic [FUNCT3_W-1:0] f3_blt  = 3'b100;
  localparam logic [FUNCT3_W-1:0] f3_bge  = 3'b101;
  localparam logic [FUNCT3_W-1:0] f3_bltu = 3'b110;
  localparam logic [FUNCT3_W-1:0] f3_bgeu = 3'b111;

  // funct7: base ops and the sub / sra variants
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    imm_i, imm_i_shift, imm_b, imm_u
  } imm_kind_t;

  typedef struct packed {
    alu_op_t               alu_op;
    logic                  b_is_imm;
    imm_kind_t             imm_kind;
    logic                  rf_we;
    reg_addr_t             rd;
    logic                  is_branch;
    logic [FUNCT3_W-1:0]   branch_funct3;
    logic                  illegal;
  } ctrl_t;

  // one record per retired instruction
  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      rf_we;
    reg_addr_t rd;
    word_t     wb_data;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== rv_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_control (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  rv_pkg::word_t   insn,
  output rv_pkg::ctrl_t         ctrl,
  output logic                  halt
);

  rv_pkg::opcode_t opcode;
  logic [rv_pkg::FUNCT3_W-1:0] funct3;
  logic [6:0] funct7;
  logic decode_we;
  logic illegal;
  logic is_ecall;
  logic halt_q;

  assign opcode = rv_pkg::opcode_t'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = rv_pkg::alu_add;
    ctrl.imm_kind = rv_pkg::imm_i;
    ctrl.rd = insn[11:7];
    ctrl.branch_funct3 = funct3;
    decode_we = 1'b0;
    illegal = 1'b0;
    is_ecall = 1'b0;

    case (opcode)
      rv_pkg::op_lui: begin
        ctrl.alu_op = rv_pkg::alu_pass_b;
        ctrl.b_is_imm = 1'b1;
        ctrl.imm_kind = rv_pkg::imm_u;
        decode_we = 1'b1;
      end
      rv_pkg::op_imm: begin
        ctrl.b_is_imm = 1'b1;
        decode_we = 1'b1;
        case (funct3)
          rv_pkg::f3_add_sub: ctrl.alu_op = rv_pkg::alu_add;
          rv_pkg::f3_slt:     ctrl.alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_sltu:    ctrl.alu_op = rv_pkg::alu_sltu;
          rv_pkg::f3_xor:     ctrl.alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_or:      ctrl.alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and:     ctrl.alu_op = rv_pkg::alu_and;
          rv_pkg::f3_sll: begin
            ctrl.alu_op = rv_pkg::alu_sll;
            ctrl.imm_kind = rv_pkg::imm_i_shift;
            illegal = (funct7 != rv_pkg::f7_base);
          end
          default: begin
            // srli / srai share funct3
            ctrl.imm_kind = rv_pkg::imm_i_shift;
            if (funct7 == rv_pkg::f7_base) begin
              ctrl.alu_op = rv_pkg::alu_srl;
            end else if (funct7 == rv_pkg::f7_alt) begin
              ctrl.alu_op = rv_pkg::alu_sra;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      rv_pkg::op_reg: begin
        decode_we = 1'b1;
        // alt funct7 only legal for sub and sra
        if (funct7 == rv_pkg::f7_alt) begin
          illegal = (funct3 != rv_pkg::f3_add_sub) && (funct3 != rv_pkg::f3_srl_sra);
        end else begin
          illegal = (funct7 != rv_pkg::f7_base);
        end
        case (funct3)
          rv_pkg::f3_add_sub: begin
            ctrl.alu_op = (funct7 == rv_pkg::f7_alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
          end
          rv_pkg::f3_sll:  ctrl.alu_op = rv_pkg::alu_sll;
          rv_pkg::f3_slt:  ctrl.alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_sltu: ctrl.alu_op = rv_pkg::alu_sltu;
          rv_pkg::f3_xor:  ctrl.alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_or:   ctrl.alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and:  ctrl.alu_op = rv_pkg::alu_and;
          default: begin
            ctrl.alu_op = (funct7 == rv_pkg::f7_alt) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          end
        endcase
      end
      rv_pkg::op_branch: begin
        ctrl.imm_kind = rv_pkg::imm_b;
        case (funct3)
          rv_pkg::f3_beq, rv_pkg::f3_bne, rv_pkg::f3_blt,
          rv_pkg::f3_bge, rv_pkg::f3_bltu, rv_pkg::f3_bgeu: ctrl.is_branch = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::op_system: begin
        // only the plain ecall encoding is accepted
        if (insn[31:7] == '0) begin
          is_ecall = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    ctrl.illegal = illegal;
    ctrl.rf_we = decode_we && !illegal && (ctrl.rd != '0) && !halt_q && !rst;
  end

  // sticky halt, set when an ecall retires
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (is_ecall) begin
      halt_q <= 1'b1;
    end
  end

  assign halt = halt_q;

endmodule

`default_nettype wire

// ==== rv_imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_imm_gen (
  input  wire  rv_pkg::word_t     insn,
  input  wire  rv_pkg::imm_kind_t kind,
  output rv_pkg::word_t           imm
);

  localparam int XLEN = rv_pkg::XLEN;

  always_comb begin
    case (kind)
      rv_pkg::imm_i: begin
        imm = {{(XLEN-12){insn[31]}}, insn[31:20]};
      end
      rv_pkg::imm_i_shift: begin
        // shamt only, upper funct7 bits are not part of the value
        imm = {{(XLEN-5){1'b0}}, insn[24:20]};
      end
      rv_pkg::imm_b: begin
        // B offsets are scattered across the word, bit 0 always zero
        imm = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
               insn[11:8], 1'b0};
      end
      default: begin
        imm = {insn[31:12], 12'd0};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    we,
  input  wire  rv_pkg::reg_addr_t rd,
  input  wire  rv_pkg::word_t     rd_data,
  input  wire  rv_pkg::reg_addr_t rs1,
  input  wire  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t           rs1_data,
  output rv_pkg::word_t           rs2_data
);

  localparam int NUM_REGS = 2 ** $bits(rv_pkg::reg_addr_t);

  rv_pkg::word_t regs [NUM_REGS];

  // x0 is never written, control already drops such writes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero regardless of contents
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  wire  rv_pkg::alu_op_t op,
  input  wire  rv_pkg::word_t   a,
  input  wire  rv_pkg::word_t   b,
  output rv_pkg::word_t         result
);

  localparam int XLEN = rv_pkg::XLEN;
  localparam int GROUPS = XLEN / 4;
  localparam int SHAMT_W = $clog2(XLEN);

  logic sub_en;
  rv_pkg::word_t b_eff;
  rv_pkg::word_t gen;
  rv_pkg::word_t prop;
  rv_pkg::word_t bit_carry;
  rv_pkg::word_t sum;
  logic [GROUPS-1:0] grp_gen;
  logic [GROUPS-1:0] grp_prop;
  logic [GROUPS:0] grp_carry;
  logic [SHAMT_W-1:0] shamt;

  // subtract is a + ~b + 1 through the same adder
  assign sub_en = (op == rv_pkg::alu_sub);
  assign b_eff = sub_en ? ~b : b;
  assign gen = a & b_eff;
  assign prop = a ^ b_eff;

  // 4-bit lookahead groups, group carries chained
  always_comb begin
    grp_carry[0] = sub_en;
    for (int k = 0; k < GROUPS; k++) begin
      grp_gen[k] = gen[4*k+3]
                 | (prop[4*k+3] & gen[4*k+2])
                 | (prop[4*k+3] & prop[4*k+2] & gen[4*k+1])
                 | (prop[4*k+3] & prop[4*k+2] & prop[4*k+1] & gen[4*k]);
      grp_prop[k] = &prop[4*k +: 4];
      grp_carry[k+1] = grp_gen[k] | (grp_prop[k] & grp_carry[k]);

      bit_carry[4*k] = grp_carry[k];
      bit_carry[4*k+1] = gen[4*k] | (prop[4*k] & grp_carry[k]);
      bit_carry[4*k+2] = gen[4*k+1]
                       | (prop[4*k+1] & gen[4*k])
                       | (prop[4*k+1] & prop[4*k] & grp_carry[k]);
      bit_carry[4*k+3] = gen[4*k+2]
                       | (prop[4*k+2] & gen[4*k+1])
                       | (prop[4*k+2] & prop[4*k+1] & gen[4*k])
                       | (prop[4*k+2] & prop[4*k+1] & prop[4*k] & grp_carry[k]);
    end
    sum = prop ^ bit_carry;
  end

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add,
      rv_pkg::alu_sub:  result = sum;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {{(XLEN-1){1'b0}}, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = b;
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                halt,
  input  wire                                is_branch,
  input  wire  [rv_pkg::FUNCT3_W-1:0]        branch_funct3,
  input  wire  rv_pkg::word_t                rs1_data,
  input  wire  rv_pkg::word_t                rs2_data,
  input  wire  rv_pkg::word_t                imm,
  output rv_pkg::word_t                      pc
);

  logic taken;
  rv_pkg::word_t pc_next;

  always_comb begin
    case (branch_funct3)
      rv_pkg::f3_beq:  taken = (rs1_data == rs2_data);
      rv_pkg::f3_bne:  taken = (rs1_data != rs2_data);
      rv_pkg::f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::f3_bltu: taken = (rs1_data < rs2_data);
      rv_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  // halted core parks on the current pc
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (is_branch && taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + rv_pkg::word_t'(4);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire  rv_pkg::word_t  insn,
  output rv_pkg::word_t        pc,
  output logic                 halt,
  output rv_pkg::retire_t      retire
);

  rv_pkg::ctrl_t ctrl;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t imm;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;

  rv_control u_control (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .ctrl (ctrl),
    .halt (halt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (ctrl.rf_we),
    .rd       (ctrl.rd),
    .rd_data  (alu_result),
    .rs1      (insn[19:15]),
    .rs2      (insn[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_imm_gen u_imm_gen (
    .insn (insn),
    .kind (ctrl.imm_kind),
    .imm  (imm)
  );

  // second operand: register or immediate
  assign alu_b = ctrl.b_is_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk           (clk),
    .rst           (rst),
    .halt          (halt),
    .is_branch     (ctrl.is_branch),
    .branch_funct3 (ctrl.branch_funct3),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .pc            (pc)
  );

  // retire record for the instruction at pc this cycle
  assign retire.valid   = !halt && !rst;
  assign retire.pc      = pc;
  assign retire.rf_we   = ctrl.rf_we;
  assign retire.rd      = ctrl.rd;
  assign retire.wb_data = alu_result;
  assign retire.illegal = ctrl.illegal;

endmodule

`default_nettype wire

// ==== rv_core_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_asserts (
  input wire                  clk,
  input wire                  rst,
  input wire rv_pkg::word_t   pc,
  input wire                  halt,
  input wire rv_pkg::retire_t retire
);

  // halt is sticky until the next reset
  halt_sticky: assert property (@(posedge clk) disable iff (rst) !$fell(halt))
    else $error("halt fell outside reset");

  // a halted core parks its pc
  pc_parked: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved while halted");

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (rst) retire.rf_we |-> retire.rd != '0)
    else $error("register write to x0");

  pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int PROG_WORDS = 200;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_HOLD = 10;
  localparam int TIMEOUT_CYCLES = 2 * PROG_WORDS + RESET_CYCLES + 50;
  localparam logic [31:0] LFSR_SEED = 32'h16729626;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic clk;
  logic rst;
  rv_pkg::word_t insn;
  rv_pkg::word_t pc;
  logic halt;
  rv_pkg::retire_t retire;

  rv_pkg::word_t prog [PROG_WORDS];
  rv_pkg::word_t model_regs [32];
  logic [31:0] lfsr_state;
  int errors;
  int checks;
  int cycles;

  rv_core UUT (.clk(clk), .rst(rst), .insn(insn), .pc(pc), .halt(halt), .retire(retire));

  bind rv_core rv_core_asserts u_asserts (
    .clk(clk), .rst(rst), .pc(pc), .halt(halt), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    // one galois step per output bit
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input rv_pkg::word_t expected,
                             input rv_pkg::word_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // ISA-level model of one instruction against model_regs
  function automatic rv_pkg::retire_t ref_model(input rv_pkg::word_t at, input rv_pkg::word_t ins,
                                                output rv_pkg::word_t next_pc, output logic ecall);
    rv_pkg::retire_t r;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t bimm;
    logic [2:0] f3;
    logic [6:0] f7;
    logic wr;
    logic ok;
    logic take;
    a = model_regs[ins[19:15]];
    f3 = ins[14:12];
    f7 = ins[31:25];
    b = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
    bimm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    r = '0;
    wr = 1'b1;
    ok = 1'b1;
    take = 1'b0;
    ecall = 1'b0;
    case (ins[6:0])
      7'h37: r.wb_data = {ins[31:12], 12'h000};
      7'h13, 7'h33: begin
        if (f3 == 3'b001) begin
          ok = (f7 == 7'h00);
        end else if (f3 == 3'b101) begin
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        end else if (ins[5]) begin
          ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000);
        end
        case (f3)
          3'b000: r.wb_data = (ins[5] && f7[5]) ? a - b : a + b;
          3'b001: r.wb_data = a << b[4:0];
          3'b010: r.wb_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: r.wb_data = (a < b) ? 32'd1 : 32'd0;
          3'b100: r.wb_data = a ^ b;
          3'b101: r.wb_data = f7[5] ? $signed(a) >>> b[4:0] : a >> b[4:0];
          3'b110: r.wb_data = a | b;
          default: r.wb_data = a & b;
        endcase
      end
      7'h63: begin
        wr = 1'b0;
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          3'b111: take = (a >= b);
          default: ok = 1'b0;
        endcase
      end
      7'h73: begin
        wr = 1'b0;
        ok = (ins[31:7] == '0);
        ecall = ok;
      end
      default: begin
        wr = 1'b0;
        ok = 1'b0;
      end
    endcase
    next_pc = at + (take ? bimm : 32'd4);
    r.valid = 1'b1;
    r.pc = at;
    r.rd = ins[11:7];
    r.illegal = !ok;
    r.rf_we = wr && ok && (r.rd != 5'd0);
    return r;
  endfunction

  function automatic rv_pkg::word_t random_alu();
    logic [3:0] sel;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    logic [24:0] junk;
    sel = take_bits(4);
    rd = take_bits(4);
    rs1 = take_bits(4);
    rs2 = take_bits(5);
    f3 = take_bits(3);
    f7 = (take_bits(1) && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
    imm = take_bits(12);
    if (sel == 4'd0) begin
      // illegal forms are mul, slli with alt funct7, a load and a bad branch funct3
      junk = take_bits(25);
      case (take_bits(2))
        0: return {7'h01, rs2, rs1, f3, rd, 7'h33};
        1: return {7'h20, rs2, rs1, 3'b001, rd, 7'h13};
        2: return {junk, 7'h03};
        default: return {7'h00, rs2, rs1, 3'b011, 5'd8, 7'h63};
      endcase
    end
    if (take_bits(1)) begin
      return {f7, 1'b0, rs2[3:0], rs1, f3, rd, 7'h33};
    end
    // rs2 field doubles as shamt here
    if (f3 == 3'b001 || f3 == 3'b101) begin
      return {f7, rs2, rs1, f3, rd, 7'h13};
    end
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  task automatic build_program();
    int idx;
    int nb;
    logic [12:0] off;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] pick;
    logic [11:0] v;
    logic [19:0] u;
    // unused words load their own index into x31
    for (int k = 0; k < PROG_WORDS; k++) begin
      prog[k] = {k[11:0], 5'd0, 3'b000, 5'd31, 7'h13};
    end
    idx = 0;
    nb = 0;
    for (int i = 0; i < 8; i++) begin
      v = take_bits(12);
      prog[idx] = {v, 5'd0, 3'b000, 5'(i + 1), 7'h13};
      idx++;
    end
    for (int j = 0; j < 150; j++) begin
      prog[idx] = random_alu();
      idx++;
      if (j % 7 == 6 && nb < 20) begin
        pick = take_bits(3);
        if (pick >= 3'd6) begin
          pick = pick - 3'd6;
        end
        rs1 = take_bits(3);
        rs2 = take_bits(3);
        // forward by 1 to 4 words
        off = 13'((take_bits(2) + 1) * 4);
        prog[idx] = {off[12], off[10:5], rs2, rs1, (pick < 3'd2) ? pick : pick + 3'd2,
                     off[4:1], off[11], 7'h63};
        idx++;
        nb++;
      end
    end
    for (int i = 0; i < 4; i++) begin
      u = take_bits(20);
      prog[idx] = {u, 5'(9 + i), 7'h37};
      idx++;
    end
    prog[idx] = 32'h00000073;
  endtask

  function automatic rv_pkg::word_t fetch(input rv_pkg::word_t addr);
    return (addr[31:2] < PROG_WORDS) ? prog[addr[31:2]] : '0;
  endfunction

  task automatic compare_retire(input rv_pkg::retire_t exp);
    check_value($sformatf("valid at %h", exp.pc), exp.valid, retire.valid);
    check_value($sformatf("retire pc at %h", exp.pc), exp.pc, retire.pc);
    check_value($sformatf("rf_we at %h", exp.pc), exp.rf_we, retire.rf_we);
    check_value($sformatf("rd at %h", exp.pc), exp.rd, retire.rd);
    check_value($sformatf("illegal at %h", exp.pc), exp.illegal, retire.illegal);
    if (exp.rf_we) begin
      check_value($sformatf("wb_data at %h", exp.pc), exp.wb_data, retire.wb_data);
    end
  endtask

  initial begin : stimulus
    rv_pkg::retire_t exp;
    rv_pkg::word_t exp_pc;
    rv_pkg::word_t next_pc;
    logic exp_halt;
    logic ecall;
    int halted_cycles;
    rst = 1'b1;
    insn = '0;
    errors = 0;
    checks = 0;
    lfsr_state = LFSR_SEED;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_value("reset pc", '0, pc);
      check_value("reset halt", '0, halt);
      insn = fetch(pc);
      #2;
      check_value("reset valid", '0, retire.valid);
      check_value("reset rf_we", '0, retire.rf_we);
    end
    @(negedge clk);
    rst = 1'b0;
    exp_pc = '0;
    exp_halt = 1'b0;
    halted_cycles = 0;
    while (halted_cycles < HALT_HOLD) begin
      check_value("pc", exp_pc, pc);
      check_value("halt", exp_halt, halt);
      insn = fetch(pc);
      #2;
      if (exp_halt) begin
        check_value("halted valid", '0, retire.valid);
        check_value("halted rf_we", '0, retire.rf_we);
        halted_cycles++;
      end else begin
        exp = ref_model(exp_pc, insn, next_pc, ecall);
        compare_retire(exp);
        if (exp.rf_we) begin
          model_regs[exp.rd] = exp.wb_data;
        end
        exp_pc = next_pc;
        exp_halt = ecall;
      end
      @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
rv_pkg.sv
rv_control.sv
rv_imm_gen.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv
